// File: tomasulo_core.f
logic/tomasulo_pkg.sv
logic/tomasulo_ifs.sv
logic/issue.sv
logic/reg_status.sv
logic/reorder_buffer.sv
logic/reservation_station.sv
logic/func_units.sv
logic/tomasulo_core.sv
testbench/clock_gen.sv
testbench/tb_tomasulo_core.sv

// File: testbench/tb_tomasulo_core.sv
module tb_tomasulo_core
    import tomasulo_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    logic clk1, reset;
    logic wb_cyc, wb_stb, wb_we, wb_ack;
    instr_t wb_dat;
    logic commit_valid;
    reg_idx_t commit_rd;
    word_t commit_value;

    instr_t program_q [$];
    int gap_q [$];
    reg_idx_t exp_rd_q [$];
    word_t exp_val_q [$];
    word_t shadow [num_regs];
    int burst_first, burst_last, burst_stalls;
    longint limit_ns;
    int drain;
    reg_idx_t exp_rd;
    word_t exp_val;

    clock_gen u_clock_gen (.clk1(clk1), .reset(reset));

    tomasulo_core u_dut (
        .clk1(clk1), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_dat(wb_dat), .wb_ack(wb_ack),
        .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_value(commit_value)
    );

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_rd(input reg_idx_t expected, input reg_idx_t actual);
        if (actual !== expected)
        begin
            $display("[FAIL] %0t commit_rd expected %0d got %0d", $time, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_value(input word_t expected, input word_t actual);
        if (actual !== expected)
        begin
            $display("[FAIL] %0t commit_value expected %04h got %04h",
                $time, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_ack(input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("[FAIL] %0t wb_ack expected %0b got %0b", $time, expected, actual);
            abort_run();
        end
    endtask

    // sequential execution of one instruction on the shadow registers
    function automatic word_t model_result(input instr_t w);
        func_t f;
        word_t a, b;
        f = w[15:12];
        a = shadow[w[7:4]];
        b = shadow[w[3:0]];
        if (f[3])
            return a * b;
        case (f[2:0])
            3'd0: return a + b;
            3'd1: return a - b;
            3'd2: return a & b;
            3'd3: return a | b;
            3'd4: return a ^ b;
            3'd5: return {8'h00, w[7:4], w[3:0]};
            default: return a;
        endcase
    endfunction

    task automatic add_instr(input func_t f, input reg_idx_t rd, input reg_idx_t rs1,
                             input reg_idx_t rs2, input int gap);
        instr_t w;
        word_t result;
        w = {f, rd, rs1, rs2};
        result = model_result(w);
        shadow[rd] = result;
        program_q.push_back(w);
        gap_q.push_back(gap);
        exp_rd_q.push_back(rd);
        exp_val_q.push_back(result);
    endtask

    task automatic build_programs();
        func_t chain_funcs [10];
        reg_idx_t prev;
        logic [7:0] imm;
        chain_funcs = '{4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd6, 4'd7, 4'd0, 4'd1, 4'd4};
        for (int r = 0; r < num_regs; r++)
            shadow[r] = '0;
        // load immediates everywhere
        for (int r = 0; r < num_regs; r++)
        begin
            imm = 8'($urandom_range(255, 1));
            add_instr(4'd5, reg_idx_t'(r), imm[7:4], imm[3:0], 0);
        end
        // dependent ALU chain
        prev = 4'd0;
        for (int k = 0; k < 10; k++)
        begin
            add_instr(chain_funcs[k], reg_idx_t'(k + 1), prev, reg_idx_t'((k + 5) % 16), 0);
            prev = reg_idx_t'(k + 1);
        end
        // long multiply chain, then independent ALU work
        add_instr(4'd8, 4'd9, 4'd2, 4'd3, 0);
        add_instr(4'd9, 4'd10, 4'd9, 4'd9, 0);
        add_instr(4'd12, 4'd11, 4'd10, 4'd4, 0);
        add_instr(4'd0, 4'd12, 4'd1, 4'd2, 0);
        add_instr(4'd1, 4'd13, 4'd3, 4'd4, 0);
        add_instr(4'd3, 4'd14, 4'd5, 4'd6, 0);
        add_instr(4'd4, 4'd15, 4'd7, 4'd8, 0);
        // write after write on r6, younger value must win
        add_instr(4'd5, 4'd6, 4'd1, 4'd2, 0);
        add_instr(4'd5, 4'd6, 4'd3, 4'd4, 0);
        add_instr(4'd0, 4'd7, 4'd6, 4'd6, 0);
        add_instr(4'd8, 4'd6, 4'd2, 4'd3, 0);
        add_instr(4'd0, 4'd6, 4'd1, 4'd1, 0);
        add_instr(4'd4, 4'd7, 4'd6, 4'd0, 0);
        // burst that should fill the stations and the reorder buffer
        burst_first = program_q.size();
        prev = 4'd3;
        for (int k = 0; k < 12; k++)
        begin
            add_instr(func_t'(8 + k % 8), reg_idx_t'(8 + k % 4), prev, 4'd2, 0);
            prev = reg_idx_t'(8 + k % 4);
        end
        for (int k = 0; k < 12; k++)
            add_instr(func_t'(k % 8), reg_idx_t'(k % 4), reg_idx_t'(8 + k % 4),
                      reg_idx_t'(k + 4), 0);
        burst_last = program_q.size() - 1;
        for (int k = 0; k < 300; k++)
            add_instr(func_t'($urandom_range(15)), reg_idx_t'($urandom_range(15)),
                      reg_idx_t'($urandom_range(15)), reg_idx_t'($urandom_range(15)),
                      $urandom_range(3));
    endtask

    // one Wishbone write per instruction, inputs change on the falling edge
    task automatic send_program();
        int waits;
        for (int i = 0; i < program_q.size(); i++)
        begin
            if (gap_q[i] > 0)
            begin
                wb_cyc = 1'b0;
                wb_stb = 1'b0;
                wb_we = 1'b0;
                repeat (gap_q[i]) @(negedge clk1);
            end
            wb_cyc = 1'b1;
            wb_stb = 1'b1;
            wb_we = 1'b1;
            wb_dat = program_q[i];
            waits = 0;
            do
            begin
                @(negedge clk1);
                waits++;
            end
            while (!wb_ack);
            if (i >= burst_first && i <= burst_last)
                burst_stalls += waits - 1;
            // word is taken on the next rising edge
            @(negedge clk1);
            // ack lasts a single cycle
            check_ack(1'b0, wb_ack);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    always @(negedge clk1)
    begin
        if (!reset && commit_valid)
        begin
            if (exp_rd_q.size() == 0)
            begin
                $display("error: commit at %0t with no instruction outstanding", $time);
                abort_run();
            end
            else
            begin
                exp_rd = exp_rd_q.pop_front();
                exp_val = exp_val_q.pop_front();
                check_rd(exp_rd, commit_rd);
                check_value(exp_val, commit_value);
            end
        end
    end

    initial
    begin
        void'($urandom(32'h77ba));
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_dat = '0;
        burst_stalls = 0;
        build_programs();
        limit_ns = (longint'(program_q.size()) * 12 + 200) * 40;
        fork
            begin
                #(limit_ns);
                $display("error: run timed out after %0d ns", limit_ns);
                abort_run();
            end
        join_none
        wait (!reset);
        @(negedge clk1);
        send_program();
        drain = 0;
        while (exp_rd_q.size() != 0 && drain < 400)
        begin
            @(negedge clk1);
            drain++;
        end
        // idle cycles catch stray commits
        repeat (20) @(negedge clk1);
        if (burst_stalls == 0)
        begin
            $display("error: ack was never withheld during the multiply burst");
            abort_run();
        end
        else if (exp_rd_q.size() != 0)
        begin
            $display("error: %0d instructions never committed", exp_rd_q.size());
            abort_run();
        end
        else
        begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end
endmodule

// File: testbench/clock_gen.sv
module clock_gen (
    output logic clk1,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        clk1 = 1'b0;
        forever #20 clk1 = ~clk1;
    end

    // released on a falling edge after 5 rising edges
    initial
    begin
        reset = 1'b1;
        repeat (5) @(posedge clk1);
        @(negedge clk1);
        reset = 1'b0;
    end
endmodule

// File: logic/tomasulo_core.sv
module tomasulo_core
    import tomasulo_pkg::*;
(
    input  logic clk1, reset,
    input  logic wb_cyc, wb_stb, wb_we,
    input  instr_t wb_dat,
    output logic wb_ack,
    output logic commit_valid,
    output reg_idx_t commit_rd,
    output word_t commit_value
);
    station_alloc_if alu_alloc ();
    station_alloc_if mul_alloc ();
    cdb_if cdb ();

    reg_idx_t rf_rs1, rf_rs2;
    word_t rf_val1, rf_val2, rob_val1, rob_val2;
    rob_tag_t rf_tag1, rf_tag2, tail_tag, commit_tag;
    logic rf_busy1, rf_busy2, rob_done1, rob_done2;
    logic rob_alloc, rob_full, rename;
    logic alu_valid, alu_hold, mul_valid;
    func_t alu_op;
    word_t alu_a, alu_b, mul_a, mul_b;
    rob_tag_t alu_tag, mul_tag;

    issue u_issue (
        .clk1(clk1), .reset(reset),
        .req(wb_cyc && wb_stb && wb_we), .instr(wb_dat), .ack(wb_ack),
        .alu_alloc(alu_alloc), .mul_alloc(mul_alloc), .cdb(cdb),
        .rf_rs1(rf_rs1), .rf_rs2(rf_rs2), .rf_val1(rf_val1), .rf_val2(rf_val2),
        .rf_tag1(rf_tag1), .rf_tag2(rf_tag2), .rf_busy1(rf_busy1), .rf_busy2(rf_busy2),
        .rob_done1(rob_done1), .rob_done2(rob_done2),
        .rob_val1(rob_val1), .rob_val2(rob_val2),
        .rob_alloc(rob_alloc), .rob_full(rob_full), .tail_tag(tail_tag), .rename(rename)
    );

    reg_status u_reg_status (
        .clk1(clk1), .reset(reset),
        .rs1(rf_rs1), .rs2(rf_rs2), .val1(rf_val1), .val2(rf_val2),
        .tag1(rf_tag1), .tag2(rf_tag2), .busy1(rf_busy1), .busy2(rf_busy2),
        .rename(rename), .rename_rd(wb_dat[11:8]), .rename_tag(tail_tag),
        .commit_valid(commit_valid), .commit_rd(commit_rd),
        .commit_value(commit_value), .commit_tag(commit_tag)
    );

    reorder_buffer u_rob (
        .clk1(clk1), .reset(reset),
        .alloc(rob_alloc), .alloc_rd(wb_dat[11:8]), .tail_tag(tail_tag), .full(rob_full),
        .cdb(cdb),
        .src_tag1(rf_tag1), .src_tag2(rf_tag2), .src_done1(rob_done1), .src_done2(rob_done2),
        .src_val1(rob_val1), .src_val2(rob_val2),
        .commit_valid(commit_valid), .commit_rd(commit_rd),
        .commit_value(commit_value), .commit_tag(commit_tag)
    );

    reservation_station u_alu_rs (
        .clk1(clk1), .reset(reset), .alloc(alu_alloc), .cdb(cdb), .hold(alu_hold),
        .issue_valid(alu_valid), .issue_op(alu_op),
        .issue_a(alu_a), .issue_b(alu_b), .issue_tag(alu_tag)
    );

    // the multiplier never stalls, its func code is not needed
    reservation_station u_mul_rs (
        .clk1(clk1), .reset(reset), .alloc(mul_alloc), .cdb(cdb), .hold(1'b0),
        .issue_valid(mul_valid), .issue_op(),
        .issue_a(mul_a), .issue_b(mul_b), .issue_tag(mul_tag)
    );

    func_units u_func_units (
        .clk1(clk1), .reset(reset),
        .alu_valid(alu_valid), .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b),
        .alu_tag(alu_tag), .alu_hold(alu_hold),
        .mul_valid(mul_valid), .mul_a(mul_a), .mul_b(mul_b), .mul_tag(mul_tag),
        .cdb(cdb)
    );

endmodule

// File: logic/func_units.sv
module func_units
    import tomasulo_pkg::*;
(
    input  logic clk1, reset,
    input  logic alu_valid,
    input  func_t alu_op,
    input  word_t alu_a, alu_b,
    input  rob_tag_t alu_tag,
    output logic alu_hold,
    input  logic mul_valid,
    input  word_t mul_a, mul_b,
    input  rob_tag_t mul_tag,
    cdb_if.drive cdb
);
    word_t alu_result, res_value;
    logic res_valid;
    rob_tag_t res_tag;
    logic [mul_latency-1:0] mv;
    rob_tag_t mtag [mul_latency];
    word_t mval [1:mul_latency-1];
    word_t part_lo, part_hi;
    logic mul_out;

    always_comb
    begin
        case (alu_op_t'(alu_op[2:0]))
            alu_add: alu_result = alu_a + alu_b;
            alu_sub: alu_result = alu_a - alu_b;
            alu_and: alu_result = alu_a & alu_b;
            alu_or: alu_result = alu_a | alu_b;
            alu_xor: alu_result = alu_a ^ alu_b;
            alu_li, alu_cpy, alu_cpy_alt: alu_result = alu_a;
            default: alu_result = alu_a;
        endcase
    end

    assign mul_out = mv[mul_latency-1];
    // result stays put while the multiplier owns the bus
    assign alu_hold = res_valid && mul_out;

    always_ff @(posedge clk1)
    begin
        if (reset)
        begin
            res_valid <= 1'b0;
            mv <= '0;
        end
        else
        begin
            res_valid <= alu_valid || alu_hold;
            mv <= {mv[mul_latency-2:0], mul_valid};
        end
    end

    always_ff @(posedge clk1)
    begin
        if (alu_valid)
        begin
            res_value <= alu_result;
            res_tag <= alu_tag;
        end
        // low 16 bits from two byte-wide partial products
        part_lo <= mul_a * mul_b[7:0];
        part_hi <= {mul_a[7:0] * mul_b[15:8], 8'h00};
        mtag[0] <= mul_tag;
        mval[1] <= part_lo + part_hi;
        mtag[1] <= mtag[0];
        for (int i = 2; i < mul_latency; i++)
        begin
            mval[i] <= mval[i-1];
            mtag[i] <= mtag[i-1];
        end
    end

    assign cdb.valid = mul_out || res_valid;
    assign cdb.tag = mul_out ? mtag[mul_latency-1] : res_tag;
    assign cdb.value = mul_out ? mval[mul_latency-1] : res_value;

endmodule

// File: logic/reservation_station.sv
module reservation_station
    import tomasulo_pkg::*;
#(
    parameter int depth = station_depth
)
(
    input  logic clk1, reset,
    station_alloc_if.accept alloc,
    cdb_if.listen cdb,
    input  logic hold,
    output logic issue_valid,
    output func_t issue_op,
    output word_t issue_a, issue_b,
    output rob_tag_t issue_tag
);
    logic [depth-1:0] busy, rj, rk, ready, oldest;
    func_t op [depth];
    word_t vj [depth];
    word_t vk [depth];
    rob_tag_t qj [depth];
    rob_tag_t qk [depth];
    rob_tag_t dest [depth];
    // bit j set when this entry came in no later than entry j
    logic [depth-1:0] older [depth];
    int sel, slot;

    assign ready = busy & rj & rk;
    assign alloc.full = &busy;

    always_comb
    begin
        sel = 0;
        slot = 0;
        for (int i = depth - 1; i >= 0; i--)
        begin
            oldest[i] = ready[i] && (ready & ~older[i]) == '0;
            if (oldest[i])
                sel = i;
            if (!busy[i])
                slot = i;
        end
    end

    assign issue_valid = |ready && !hold;
    assign issue_op = op[sel];
    assign issue_a = vj[sel];
    assign issue_b = vk[sel];
    assign issue_tag = dest[sel];

    always_ff @(posedge clk1)
    begin
        if (reset)
            busy <= '0;
        else
        begin
            if (issue_valid)
                busy[sel] <= 1'b0;
            if (alloc.valid)
                busy[slot] <= 1'b1;
        end
    end

    always_ff @(posedge clk1)
    begin
        for (int i = 0; i < depth; i++)
        begin
            if (cdb.valid && !rj[i] && qj[i] == cdb.tag)
            begin
                vj[i] <= cdb.value;
                rj[i] <= 1'b1;
            end
            if (cdb.valid && !rk[i] && qk[i] == cdb.tag)
            begin
                vk[i] <= cdb.value;
                rk[i] <= 1'b1;
            end
            if (alloc.valid && busy[i])
                older[i][slot] <= 1'b1;
        end
        if (alloc.valid)
        begin
            op[slot] <= alloc.op;
            vj[slot] <= alloc.vj;
            vk[slot] <= alloc.vk;
            qj[slot] <= alloc.qj;
            qk[slot] <= alloc.qk;
            rj[slot] <= alloc.rj;
            rk[slot] <= alloc.rk;
            dest[slot] <= alloc.dest;
            // newest entry, counted as older than itself only
            older[slot] <= '0;
            older[slot][slot] <= 1'b1;
        end
    end

endmodule

// File: logic/reorder_buffer.sv
module reorder_buffer
    import tomasulo_pkg::*;
(
    input  logic clk1, reset,
    input  logic alloc,
    input  reg_idx_t alloc_rd,
    output rob_tag_t tail_tag,
    output logic full,
    cdb_if.listen cdb,
    input  rob_tag_t src_tag1, src_tag2,
    output logic src_done1, src_done2,
    output word_t src_val1, src_val2,
    output logic commit_valid,
    output reg_idx_t commit_rd,
    output word_t commit_value,
    output rob_tag_t commit_tag
);
    rob_state_t state [rob_depth];
    reg_idx_t rd [rob_depth];
    word_t value [rob_depth];
    rob_tag_t head, tail;
    logic [rob_count_w-1:0] count;
    logic retire;

    assign tail_tag = tail;
    assign full = count == rob_count_w'(rob_depth);
    assign retire = state[head] == rob_done;

    assign commit_valid = retire;
    assign commit_rd = rd[head];
    assign commit_value = value[head];
    assign commit_tag = head;

    // operand lookup for issue
    assign src_done1 = state[src_tag1] == rob_done;
    assign src_done2 = state[src_tag2] == rob_done;
    assign src_val1 = value[src_tag1];
    assign src_val2 = value[src_tag2];

    always_ff @(posedge clk1)
    begin
        if (reset)
        begin
            head <= '0;
            tail <= '0;
            count <= '0;
            for (int i = 0; i < rob_depth; i++)
                state[i] <= rob_free;
        end
        else
        begin
            if (alloc)
            begin
                state[tail] <= rob_waiting;
                tail <= tail + 1'b1;
            end
            if (cdb.valid)
                state[cdb.tag] <= rob_done;
            if (retire)
            begin
                state[head] <= rob_free;
                head <= head + 1'b1;
            end
            count <= count + rob_count_w'(alloc) - rob_count_w'(retire);
        end
    end

    always_ff @(posedge clk1)
    begin
        if (alloc)
            rd[tail] <= alloc_rd;
        if (cdb.valid)
            value[cdb.tag] <= cdb.value;
    end

endmodule

// File: logic/reg_status.sv
module reg_status
    import tomasulo_pkg::*;
(
    input  logic clk1, reset,
    input  reg_idx_t rs1, rs2,
    output word_t val1, val2,
    output rob_tag_t tag1, tag2,
    output logic busy1, busy2,
    input  logic rename,
    input  reg_idx_t rename_rd,
    input  rob_tag_t rename_tag,
    input  logic commit_valid,
    input  reg_idx_t commit_rd,
    input  word_t commit_value,
    input  rob_tag_t commit_tag
);
    word_t regs [num_regs];
    rob_tag_t tags [num_regs];
    logic [num_regs-1:0] busy;

    assign val1 = regs[rs1];
    assign val2 = regs[rs2];
    assign tag1 = tags[rs1];
    assign tag2 = tags[rs2];
    assign busy1 = busy[rs1];
    assign busy2 = busy[rs2];

    always_ff @(posedge clk1)
    begin
        if (reset)
        begin
            busy <= '0;
            for (int i = 0; i < num_regs; i++)
                regs[i] <= '0;
        end
        else
        begin
            if (commit_valid)
            begin
                regs[commit_rd] <= commit_value;
                // only the newest producer frees the register
                if (tags[commit_rd] == commit_tag)
                    busy[commit_rd] <= 1'b0;
            end
            // a rename in the same cycle keeps it busy
            if (rename)
                busy[rename_rd] <= 1'b1;
        end
    end

    always_ff @(posedge clk1)
    begin
        if (rename)
            tags[rename_rd] <= rename_tag;
    end

endmodule

// File: logic/issue.sv
module issue
    import tomasulo_pkg::*;
(
    input  logic clk1, reset,
    input  logic req,
    input  instr_t instr,
    output logic ack,
    station_alloc_if.alloc alu_alloc,
    station_alloc_if.alloc mul_alloc,
    cdb_if.listen cdb,
    output reg_idx_t rf_rs1, rf_rs2,
    input  word_t rf_val1, rf_val2,
    input  rob_tag_t rf_tag1, rf_tag2,
    input  logic rf_busy1, rf_busy2,
    input  logic rob_done1, rob_done2,
    input  word_t rob_val1, rob_val2,
    output logic rob_alloc,
    input  logic rob_full,
    input  rob_tag_t tail_tag,
    output logic rename
);
    func_t func;
    logic to_mul, imm_op, one_src, target_full;
    logic ack_q;
    word_t vj, vk;
    logic rj, rk;

    assign func = instr[15:12];
    assign rf_rs1 = instr[7:4];
    assign rf_rs2 = instr[3:0];
    assign to_mul = func[func_mul_bit];
    assign imm_op = !to_mul && alu_op_t'(func[2:0]) == alu_li;
    assign one_src = !to_mul && func[2:1] == 2'b11;
    assign target_full = to_mul ? mul_alloc.full : alu_alloc.full;

    // resources checked a cycle ahead; nothing else allocates in between
    always_ff @(posedge clk1)
    begin
        if (reset)
            ack_q <= 1'b0;
        else
            ack_q <= req && !ack_q && !rob_full && !target_full;
    end

    assign ack = ack_q && req;
    assign rob_alloc = ack;
    assign rename = ack;

    // register file, then finished rob entry, then the bus this cycle
    always_comb
    begin
        rj = 1'b1;
        rk = 1'b1;
        if (!rf_busy1)
            vj = rf_val1;
        else if (rob_done1)
            vj = rob_val1;
        else if (cdb.valid && cdb.tag == rf_tag1)
            vj = cdb.value;
        else
        begin
            vj = '0;
            rj = 1'b0;
        end
        if (!rf_busy2)
            vk = rf_val2;
        else if (rob_done2)
            vk = rob_val2;
        else if (cdb.valid && cdb.tag == rf_tag2)
            vk = cdb.value;
        else
        begin
            vk = '0;
            rk = 1'b0;
        end
        if (imm_op)
        begin
            vj = {8'h00, rf_rs1, rf_rs2};
            rj = 1'b1;
            rk = 1'b1;
        end
        if (one_src)
            rk = 1'b1;
    end

    assign alu_alloc.valid = ack && !to_mul;
    assign mul_alloc.valid = ack && to_mul;
    assign alu_alloc.op = func;
    assign mul_alloc.op = func;
    assign alu_alloc.vj = vj;
    assign mul_alloc.vj = vj;
    assign alu_alloc.vk = vk;
    assign mul_alloc.vk = vk;
    assign alu_alloc.qj = rf_tag1;
    assign mul_alloc.qj = rf_tag1;
    assign alu_alloc.qk = rf_tag2;
    assign mul_alloc.qk = rf_tag2;
    assign alu_alloc.rj = rj;
    assign mul_alloc.rj = rj;
    assign alu_alloc.rk = rk;
    assign mul_alloc.rk = rk;
    assign alu_alloc.dest = tail_tag;
    assign mul_alloc.dest = tail_tag;

endmodule

// File: logic/tomasulo_ifs.sv
interface station_alloc_if
    import tomasulo_pkg::*;
();
    logic valid;
    func_t op;
    word_t vj, vk;
    rob_tag_t qj, qk;
    // operand ready flags
    logic rj, rk;
    rob_tag_t dest;
    logic full;

    modport alloc (
        output valid, op, vj, vk, qj, qk, rj, rk, dest,
        input full
    );

    modport accept (
        input valid, op, vj, vk, qj, qk, rj, rk, dest,
        output full
    );
endinterface

interface cdb_if
    import tomasulo_pkg::*;
();
    logic valid;
    rob_tag_t tag;
    word_t value;

    modport drive (
        output valid, tag, value
    );

    modport listen (
        input valid, tag, value
    );
endinterface

// File: logic/tomasulo_pkg.sv
package tomasulo_pkg;

    localparam int num_regs = 16;
    localparam int rob_depth = 8;
    localparam int rob_count_w = $clog2(rob_depth + 1);
    localparam int station_depth = 3;
    localparam int mul_latency = 3;
    localparam int func_mul_bit = 3;

    typedef logic [15:0] word_t;
    typedef logic [3:0] reg_idx_t;
    typedef logic [3:0] func_t;
    typedef logic [2:0] rob_tag_t;

    // func, rd, rs1, rs2 from the top
    typedef logic [15:0] instr_t;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or = 3'd3,
        alu_xor = 3'd4,
        alu_li = 3'd5,
        alu_cpy = 3'd6,
        alu_cpy_alt = 3'd7
    } alu_op_t;

    typedef enum logic [1:0] {
        rob_free,
        rob_waiting,
        rob_done
    } rob_state_t;

endpackage
